/* design/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
  input  logic                clock,
  input  logic                reset,
  input  itim_pkg::fetch_req_t fetch_req,
  output itim_pkg::fetch_rsp_t fetch_rsp,
  input  itim_pkg::load_req_t load_req
);

  itim_pkg::mem_req_t mem_req;
  itim_pkg::mem_rsp_t mem_rsp;

  itim itim_i (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  // refills and bypass reads land here.
  imem_backing imem_i (
    .clock    (clock),
    .reset    (reset),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .load_req (load_req)
  );

endmodule

/* design/imem_backing.sv */
`timescale 1ns/10ps
`include "itim_defs.svh"

module imem_backing (
  input  logic                clock,
  input  logic                reset,
  input  itim_pkg::mem_req_t  mem_req,
  output itim_pkg::mem_rsp_t  mem_rsp,
  input  itim_pkg::load_req_t load_req
);

  localparam int unsigned index_bits = $clog2(`IMEM_WORDS);
  localparam int unsigned count_bits = $clog2(`IMEM_LATENCY + 1);
  localparam logic [count_bits-1:0] last_count = count_bits'(`IMEM_LATENCY - 1);

  logic [31:0]           mem_array [`IMEM_WORDS];
  logic                  busy;
  logic                  ready_q;
  logic [count_bits-1:0] count;
  logic [index_bits-1:0] index_q;
  logic [31:0]           rdata_q;
  logic                  start;
  logic                  done;

  // the cycle after ready is skipped so the new address is seen.
  assign start = !busy && !ready_q && mem_req.valid;
  assign done = busy && (count == last_count);

  always_ff @(posedge clock) begin
    if (load_req.en) begin
      mem_array[load_req.addr] <= load_req.data;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      index_q <= mem_req.addr[index_bits+1:2];   // wraps modulo size.
    end
    if (done) begin
      rdata_q <= mem_array[index_q];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy <= 1'b0;
      ready_q <= 1'b0;
      count <= '0;
    end else begin
      ready_q <= done;
      if (start) begin
        busy <= 1'b1;
        count <= '0;
      end else if (done) begin
        busy <= 1'b0;
      end else if (busy) begin
        count <= count + 1'b1;
      end
    end
  end

  assign mem_rsp.ready = ready_q;
  assign mem_rsp.rdata = rdata_q;

endmodule

/* design/itim.sv */
`timescale 1ns/10ps
`include "itim_defs.svh"

module itim (
  input  logic                 clock,
  input  logic                 reset,
  input  itim_pkg::fetch_req_t fetch_req,
  output itim_pkg::fetch_rsp_t fetch_rsp,
  output itim_pkg::mem_req_t   mem_req,
  input  itim_pkg::mem_rsp_t   mem_rsp
);

  itim_pkg::itim_ram_in_t  ram_in [`ITIM_WIDTH];
  itim_pkg::itim_ram_out_t ram_out [`ITIM_WIDTH];

  itim_ctrl ctrl_i (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .ram_in    (ram_in),
    .ram_out   (ram_out),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  // one ram per word position in a line.
  for (genvar i = 0; i < `ITIM_WIDTH; i++) begin : g_bank
    itim_ram ram_i (
      .clock   (clock),
      .ram_in  (ram_in[i]),
      .ram_out (ram_out[i])
    );
  end

endmodule

/* design/itim_ctrl.sv */
`timescale 1ns/10ps
`include "itim_defs.svh"

module itim_ctrl (
  input  logic                    clock,
  input  logic                    reset,
  input  itim_pkg::fetch_req_t    fetch_req,
  output itim_pkg::fetch_rsp_t    fetch_rsp,
  output itim_pkg::itim_ram_in_t  ram_in [`ITIM_WIDTH],
  input  itim_pkg::itim_ram_out_t ram_out [`ITIM_WIDTH],
  output itim_pkg::mem_req_t      mem_req,
  input  itim_pkg::mem_rsp_t      mem_rsp
);

  localparam int unsigned bank_bits = `ITIM_BANK_BITS;

  localparam logic [1:0] st_hit = 2'd0;   // idle, serves hits.
  localparam logic [1:0] st_miss = 2'd1;   // fill from backing memory.
  localparam logic [1:0] st_load = 2'd2;   // bypass, no write.
  localparam logic [1:0] st_fence = 2'd3;

  typedef struct packed {
    logic                 enable;
    logic                 fence;
    itim_pkg::itim_addr_u addr0;
    itim_pkg::itim_addr_u addr1;
  } front_t;

  typedef struct packed {
    logic [1:0]                state;
    logic                      second;   // waiting on the addr+4 word.
    logic                      fill0;
    logic                      fill1;
    itim_pkg::itim_addr_u      addr0;
    itim_pkg::itim_addr_u      addr1;
    logic [`ITIM_SET_BITS-1:0] fence_set;
    logic [31:0]               low_word;
  } back_t;

  front_t front_q;
  front_t front_d;
  back_t  back_q;
  back_t  back_d;

  itim_pkg::itim_entry_t      entry0;
  itim_pkg::itim_entry_t      entry1;
  logic                       in_window;
  logic                       clear;
  logic                       wr_en;
  logic [`ITIM_BANK_BITS-1:0] wr_bank;
  logic [`ITIM_SET_BITS-1:0]  wr_set;
  itim_pkg::itim_entry_t      wr_entry;

  always_comb begin
    front_d = front_q;
    front_d.enable = fetch_req.valid;
    front_d.fence = fetch_req.valid & fetch_req.fence;
    if (fetch_req.valid) begin
      front_d.addr0.raw = fetch_req.addr;
      front_d.addr1.raw = fetch_req.addr + 32'd4;
    end
  end

  // consecutive words never share a bank.
  assign entry0 = ram_out[front_q.addr0.f.bank].rdata;
  assign entry1 = ram_out[front_q.addr1.f.bank].rdata;

  assign in_window = (front_q.addr0.raw >= `ITIM_BASE_ADDR) &&
                     (front_q.addr0.raw < `ITIM_TOP_ADDR) &&
                     (front_q.addr1.raw >= `ITIM_BASE_ADDR) &&
                     (front_q.addr1.raw < `ITIM_TOP_ADDR);

  always_comb begin
    back_d = back_q;
    fetch_rsp.ready = 1'b0;
    fetch_rsp.rdata = '0;
    clear = 1'b0;
    wr_en = 1'b0;
    wr_bank = back_q.addr0.f.bank;
    wr_set = back_q.addr0.f.set;
    wr_entry = '0;

    case (back_q.state)
      st_hit: begin
        if (front_q.enable) begin
          back_d.addr0 = front_q.addr0;
          back_d.addr1 = front_q.addr1;
          back_d.second = 1'b0;
          back_d.fill0 = ~entry0.lock;   // locked entries are kept.
          back_d.fill1 = ~entry1.lock;
          if (front_q.fence) begin
            back_d.state = st_fence;
            back_d.fence_set = '0;
          end else if (!in_window) begin
            back_d.state = st_load;
          end else if (!entry0.lock || !entry1.lock) begin
            back_d.state = st_miss;
          end else if ((entry0.tag != front_q.addr0.f.tag) ||
                       (entry1.tag != front_q.addr1.f.tag)) begin
            back_d.state = st_load;
          end else begin
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = {entry1.data, entry0.data};
          end
        end
      end

      st_miss, st_load: begin
        if (mem_rsp.ready) begin
          wr_entry.lock = 1'b1;
          wr_entry.data = mem_rsp.rdata;
          if (back_q.second) begin
            wr_bank = back_q.addr1.f.bank;
            wr_set = back_q.addr1.f.set;
            wr_entry.tag = back_q.addr1.f.tag;
            wr_en = (back_q.state == st_miss) && back_q.fill1;
            fetch_rsp.ready = 1'b1;
            fetch_rsp.rdata = {mem_rsp.rdata, back_q.low_word};
            back_d.second = 1'b0;
            back_d.state = st_hit;
          end else begin
            wr_entry.tag = back_q.addr0.f.tag;
            wr_en = (back_q.state == st_miss) && back_q.fill0;
            back_d.low_word = mem_rsp.rdata;
            back_d.second = 1'b1;
          end
        end
      end

      default: begin
        // one set of every bank per cycle.
        clear = 1'b1;
        if (&back_q.fence_set) begin
          fetch_rsp.ready = 1'b1;
          back_d.state = st_hit;
        end else begin
          back_d.fence_set = back_q.fence_set + 1'b1;
        end
      end
    endcase
  end

  always_comb begin
    for (int i = 0; i < `ITIM_WIDTH; i++) begin
      // read ports follow the incoming request.
      if (front_d.addr1.f.bank == bank_bits'(i)) begin
        ram_in[i].raddr = front_d.addr1.f.set;
      end else begin
        ram_in[i].raddr = front_d.addr0.f.set;
      end
      ram_in[i].wen = clear | (wr_en & (wr_bank == bank_bits'(i)));
      if (clear) begin
        ram_in[i].waddr = back_q.fence_set;
        ram_in[i].wdata = '0;
      end else begin
        ram_in[i].waddr = wr_set;
        ram_in[i].wdata = wr_entry;
      end
    end
  end

  // held until the word returns, then advanced to addr+4.
  assign mem_req.valid = (back_q.state == st_miss) || (back_q.state == st_load);
  assign mem_req.addr = back_q.second ? back_q.addr1.raw : back_q.addr0.raw;

  always_ff @(posedge clock) begin
    if (!reset) begin
      front_q <= '0;
      back_q <= '0;   // st_hit.
    end else begin
      front_q <= front_d;
      back_q <= back_d;
    end
  end

endmodule

/* design/itim_defs.svh */
`ifndef ITIM_DEFS_SVH
`define ITIM_DEFS_SVH

// sets per bank, power of two.
`define ITIM_DEPTH 16
// banks, also words per line.
`define ITIM_WIDTH 4

// cacheable byte window, top excluded.
`define ITIM_BASE_ADDR 32'h0000_0100
`define ITIM_TOP_ADDR 32'h0000_0300

`define IMEM_WORDS 256
`define IMEM_LATENCY 2

`define ITIM_SET_BITS $clog2(`ITIM_DEPTH)
`define ITIM_BANK_BITS $clog2(`ITIM_WIDTH)
`define ITIM_TAG_BITS (30 - `ITIM_SET_BITS - `ITIM_BANK_BITS)

`endif

/* design/itim_pkg.sv */
`include "itim_defs.svh"

package itim_pkg;

  typedef struct packed {
    logic [`ITIM_TAG_BITS-1:0]  tag;
    logic [`ITIM_SET_BITS-1:0]  set;
    logic [`ITIM_BANK_BITS-1:0] bank;
    logic [1:0]                 offset;
  } itim_addr_fields_t;

  // fetch address seen raw or split for lookup.
  typedef union packed {
    logic [31:0]       raw;
    itim_addr_fields_t f;
  } itim_addr_u;

  typedef struct packed {
    logic                      lock;
    logic [`ITIM_TAG_BITS-1:0] tag;
    logic [31:0]               data;
  } itim_entry_t;

  typedef struct packed {
    logic                      wen;
    logic [`ITIM_SET_BITS-1:0] waddr;
    logic [`ITIM_SET_BITS-1:0] raddr;
    itim_entry_t               wdata;
  } itim_ram_in_t;

  typedef struct packed {
    itim_entry_t rdata;
  } itim_ram_out_t;

  typedef struct packed {
    logic        valid;
    logic        fence;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic [63:0] rdata;   // word at addr in the low half.
  } fetch_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                           en;
    logic [$clog2(`IMEM_WORDS)-1:0] addr;   // word index.
    logic [31:0]                    data;
  } load_req_t;

endpackage

/* design/itim_ram.sv */
`timescale 1ns/10ps
`include "itim_defs.svh"

module itim_ram (
  input  logic                    clock,
  input  itim_pkg::itim_ram_in_t  ram_in,
  output itim_pkg::itim_ram_out_t ram_out
);

  itim_pkg::itim_entry_t ram_array [`ITIM_DEPTH] = '{default: '0};

  logic [`ITIM_SET_BITS-1:0] raddr_q = '0;

  always_ff @(posedge clock) begin
    raddr_q <= ram_in.raddr;
    if (ram_in.wen) begin
      ram_array[ram_in.waddr] <= ram_in.wdata;
    end
  end

  // data follows the registered address.
  assign ram_out.rdata = ram_array[raddr_q];

endmodule

/* filelist.f */
+incdir+design
design/itim_pkg.sv
design/itim_ram.sv
design/itim_ctrl.sv
design/itim.sv
design/imem_backing.sv
design/fetch_top.sv
verification/itim_tb.sv

/* verification/itim_tb.sv */
`timescale 1ns/10ps
`include "itim_defs.svh"

module itim_tb;

  localparam int clock_period = 20;
  localparam int reset_cycles = 16;
  localparam int index_bits = $clog2(`IMEM_WORDS);
  localparam int fill_count = 24;
  localparam logic [31:0] tag_span = 32'd1 << (`ITIM_SET_BITS + `ITIM_BANK_BITS + 2);
  // cold fill, hits, bypass, stale, fence and line crossing.
  localparam int total_requests = 2 * fill_count + 13;
  localparam int request_cycles = 2 * `IMEM_LATENCY + `ITIM_DEPTH + 8;
  localparam int watchdog_cycles = reset_cycles + 2 * (`IMEM_WORDS + 8) +
                                   total_requests * request_cycles;

  logic                 clock;
  logic                 reset;
  itim_pkg::fetch_req_t fetch_req;
  itim_pkg::fetch_rsp_t fetch_rsp;
  itim_pkg::load_req_t  load_req;

  // shadow of the backing memory and the itim contents.
  logic [31:0]               mem_m [`IMEM_WORDS];
  logic                      lock_m [`ITIM_WIDTH][`ITIM_DEPTH];
  logic [`ITIM_TAG_BITS-1:0] tag_m [`ITIM_WIDTH][`ITIM_DEPTH];
  logic [31:0]               data_m [`ITIM_WIDTH][`ITIM_DEPTH];

  int pass_count = 0;
  int fail_count = 0;

  fetch_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .load_req  (load_req)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #(clock_period * watchdog_cycles);
    $display("timeout: fetch ready never arrived within %0d cycles", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= `ITIM_BASE_ADDR) && (addr < `ITIM_TOP_ADDR);
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return mem_m[addr[index_bits+1:2]];
  endfunction

  function automatic logic [31:0] random_window_addr();
    int unsigned words;
    words = (`ITIM_TOP_ADDR - `ITIM_BASE_ADDR) / 4;
    return `ITIM_BASE_ADDR + 4 * ($urandom % (words - 1));   // addr+4 stays inside.
  endfunction

  task automatic clear_model();
    for (int b = 0; b < `ITIM_WIDTH; b++) begin
      for (int s = 0; s < `ITIM_DEPTH; s++) begin
        lock_m[b][s] = 1'b0;
        tag_m[b][s] = '0;
        data_m[b][s] = '0;
      end
    end
  endtask

  // both entries locked with matching tags.
  function automatic logic model_hits(input logic [31:0] addr);
    itim_pkg::itim_addr_u a0;
    itim_pkg::itim_addr_u a1;
    a0.raw = addr;
    a1.raw = addr + 32'd4;
    return in_window(a0.raw) && in_window(a1.raw) &&
           lock_m[a0.f.bank][a0.f.set] && lock_m[a1.f.bank][a1.f.set] &&
           (tag_m[a0.f.bank][a0.f.set] == a0.f.tag) &&
           (tag_m[a1.f.bank][a1.f.set] == a1.f.tag);
  endfunction

  task automatic model_access(input logic [31:0] addr, input logic fence,
                              output logic [63:0] data, output logic hit);
    itim_pkg::itim_addr_u a0;
    itim_pkg::itim_addr_u a1;
    logic [31:0]          w0;
    logic [31:0]          w1;
    a0.raw = addr;
    a1.raw = addr + 32'd4;
    w0 = mem_word(a0.raw);
    w1 = mem_word(a1.raw);
    hit = 1'b0;
    data = {w1, w0};
    if (fence) begin
      clear_model();
      data = '0;
    end else if (model_hits(addr)) begin
      hit = 1'b1;
      data = {data_m[a1.f.bank][a1.f.set], data_m[a0.f.bank][a0.f.set]};
    end else if (in_window(a0.raw) && in_window(a1.raw)) begin
      // only unlocked entries take the fill.
      if (!lock_m[a0.f.bank][a0.f.set]) begin
        lock_m[a0.f.bank][a0.f.set] = 1'b1;
        tag_m[a0.f.bank][a0.f.set] = a0.f.tag;
        data_m[a0.f.bank][a0.f.set] = w0;
      end
      if (!lock_m[a1.f.bank][a1.f.set]) begin
        lock_m[a1.f.bank][a1.f.set] = 1'b1;
        tag_m[a1.f.bank][a1.f.set] = a1.f.tag;
        data_m[a1.f.bank][a1.f.set] = w1;
      end
    end
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clock);
    load_req.en <= 1'b1;
    load_req.addr <= addr[index_bits+1:2];
    load_req.data <= data;
    mem_m[addr[index_bits+1:2]] = data;
    @(posedge clock);
    load_req.en <= 1'b0;
  endtask

  task automatic run_fetch(input string name, input logic [31:0] addr, input logic fence);
    logic [63:0] exp_data;
    logic        exp_hit;
    logic [63:0] got;
    int          cycles;
    model_access(addr, fence, exp_data, exp_hit);
    @(posedge clock);
    fetch_req.valid <= 1'b1;
    fetch_req.fence <= fence;
    fetch_req.addr <= addr;
    @(posedge clock);   // request sampled here.
    fetch_req.valid <= 1'b0;
    fetch_req.fence <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!fetch_rsp.ready);
    got = fetch_rsp.rdata;
    compare(name, exp_data, got);
    compare({name, " one cycle hit"}, {63'd0, exp_hit}, {63'd0, cycles == 1});
  endtask

  task automatic report_test(input string name, input int begin_fails);
    $display("test %s finished with %0d errors", name, fail_count - begin_fails);
  endtask

  initial begin
    logic [31:0] addr;
    logic [31:0] hit_addr;
    logic [31:0] conf_addr;
    logic [31:0] filled [$];
    int          begin_fails;

    void'($urandom(32'h4ad5));
    reset = 1'b0;
    fetch_req = '0;
    load_req = '0;
    clear_model();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;

    for (int i = 0; i < `IMEM_WORDS; i++) begin
      load_word(32'(i) * 4, $urandom);
    end

    begin_fails = fail_count;
    for (int i = 0; i < fill_count; i++) begin
      addr = random_window_addr();
      filled.push_back(addr);
      run_fetch("cold_fill", addr, 1'b0);
    end
    report_test("cold_fill", begin_fails);

    begin_fails = fail_count;
    hit_addr = filled[0];   // first fill always lands.
    foreach (filled[i]) begin
      if (model_hits(filled[i])) begin
        run_fetch("hit_after_fill", filled[i], 1'b0);
      end
    end
    report_test("hit_after_fill", begin_fails);

    begin_fails = fail_count;
    addr = `ITIM_TOP_ADDR + 4 * ($urandom % 32);
    run_fetch("bypass_window", addr, 1'b0);
    load_word(addr, $urandom);
    run_fetch("bypass_window", addr, 1'b0);
    conf_addr = hit_addr + tag_span;   // same sets, other tag.
    if (!in_window(conf_addr) || !in_window(conf_addr + 32'd4)) begin
      conf_addr = hit_addr - tag_span;
    end
    run_fetch("bypass_tag", conf_addr, 1'b0);
    load_word(conf_addr, $urandom);
    run_fetch("bypass_tag", conf_addr, 1'b0);
    report_test("bypass", begin_fails);

    begin_fails = fail_count;
    load_word(hit_addr, $urandom);
    load_word(hit_addr + 32'd4, $urandom);
    run_fetch("stale_until_fence", hit_addr, 1'b0);
    report_test("stale_until_fence", begin_fails);

    begin_fails = fail_count;
    run_fetch("fence", hit_addr, 1'b1);
    run_fetch("fence_refill", hit_addr, 1'b0);
    run_fetch("fence_refill", hit_addr, 1'b0);
    report_test("fence", begin_fails);

    begin_fails = fail_count;
    run_fetch("line_cross_fence", hit_addr, 1'b1);   // empty itim, so both lines fill.
    addr = `ITIM_BASE_ADDR + ($urandom % `ITIM_DEPTH) * `ITIM_WIDTH * 4 + (`ITIM_WIDTH - 1) * 4;
    run_fetch("line_cross", addr, 1'b0);
    run_fetch("line_cross", addr, 1'b0);
    addr = `ITIM_BASE_ADDR + `ITIM_DEPTH * `ITIM_WIDTH * 4 - 4;   // last set, last bank.
    run_fetch("line_cross_tag", addr, 1'b0);
    run_fetch("line_cross_tag", addr, 1'b0);
    report_test("line_cross", begin_fails);

    $display("checks passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
